//--- hw/game_cfg.svh
/*
 * game configuration macros
 * stage count, boss stage index and synchronizer depth
 */

`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

`define GAME_NUM_STAGES 4 // stages per game, boss included

// the last stage is always the boss fight
`define GAME_BOSS_STAGE (`GAME_NUM_STAGES - 1)

`define GAME_SYNC_DEPTH 2 // flops per board switch synchronizer

`endif

//--- hw/game_pkg.sv
/*
 * game control types
 * state enum, stage index and the packed command, enable and status bundles
 */

package game_pkg;

	typedef enum logic [2:0] {
		ST_RESET     = 3'd0,
		ST_RUN       = 3'd1,
		ST_PAUSE     = 3'd2,
		ST_STAGE_WON = 3'd3,
		ST_GAME_OVER = 3'd4,
		ST_GAME_WON  = 3'd5
	} game_state_t;

	typedef logic [2:0] stage_num_t;

	typedef struct packed {
		logic start; // level, synchronized
		logic pause; // level, synchronized
		logic skip;  // single cycle pulse
	} board_cmd_t;

	typedef struct packed {
		logic player;
		logic monst;
		logic astero;
		logic boss;
	} block_enables_t;

	// both active low
	typedef struct packed {
		logic player_n;
		logic monst_n;
	} block_resets_t;

	typedef struct packed {
		stage_num_t  stage;
		game_state_t state;
		logic        won;
		logic        over;
	} game_status_t;

endpackage

//--- hw/input_conditioner.sv
/*
 * board input conditioner
 * synchronizes start, pause and skip, turns skip into a one cycle pulse
 */

`timescale 1ns/1ns
`include "game_cfg.svh"

module input_conditioner (
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 start_sw,
	input  logic                 pause_sw,
	input  logic                 skip_btn,
	output game_pkg::board_cmd_t cmd
);

	import game_pkg::*;

	board_cmd_t [`GAME_SYNC_DEPTH-1:0] sync_q; // skip field holds the raw level here
	logic                              skip_d; // synced skip, one cycle late
	logic                              skip_pulse;

	// one shift chain carries all three switches
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			sync_q <= '0;
		end else begin
			sync_q[0] <= '{start: start_sw, pause: pause_sw, skip: skip_btn};
			for (int i = 1; i < `GAME_SYNC_DEPTH; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			skip_d     <= 1'b0;
			skip_pulse <= 1'b0;
		end else begin
			skip_d     <= sync_q[`GAME_SYNC_DEPTH-1].skip;
			skip_pulse <= sync_q[`GAME_SYNC_DEPTH-1].skip & ~skip_d; // rising edge only
		end
	end

	always_comb begin
		cmd.start = sync_q[`GAME_SYNC_DEPTH-1].start;
		cmd.pause = sync_q[`GAME_SYNC_DEPTH-1].pause;
		cmd.skip  = skip_pulse;
	end

	// a held button must not keep advancing stages
	a_skip_single: assert property (@(posedge clk) disable iff (!resetN)
		cmd.skip |=> !cmd.skip)
		else $error("skip pulse longer than one cycle");

endmodule

//--- hw/stage_controller.sv
/*
 * stage sequencer
 * stage counter, enemy enables per stage kind, last stage flag
 */

`timescale 1ns/1ns
`include "game_cfg.svh"

module stage_controller (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     stage_advance,
	input  logic                     game_restart,
	output game_pkg::stage_num_t     stage,
	output game_pkg::block_enables_t enemy_en,
	output logic                     last_stage
);

	import game_pkg::*;

	localparam stage_num_t BOSS_STAGE = stage_num_t'(`GAME_BOSS_STAGE);

	stage_num_t stage_q;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			stage_q <= '0;
		end else if (game_restart) begin
			stage_q <= '0; // new game starts at stage 0
		end else if (stage_advance && (stage_q != BOSS_STAGE)) begin
			stage_q <= stage_q + 3'd1; // saturates at the boss
		end
	end

	assign stage      = stage_q;
	assign last_stage = (stage_q == BOSS_STAGE);

	// enemy mix of each stage
	always_comb begin
		enemy_en = '0; // player bit is never driven here
		if (stage_q < BOSS_STAGE) begin
			enemy_en.monst  = 1'b1;
			enemy_en.astero = stage_q[0]; // asteroids on odd stages
		end else begin
			enemy_en.boss = 1'b1; // boss fights alone
		end
	end

	a_stage_range: assert property (@(posedge clk) disable iff (!resetN)
		stage_q <= BOSS_STAGE)
		else $error("stage index past boss stage");

	// advance on the boss stage would mean the FSM missed the final win
	a_no_advance_at_boss: assert property (@(posedge clk) disable iff (!resetN)
		stage_advance |-> !last_stage)
		else $error("stage advance requested on the boss stage");

endmodule

//--- hw/game_controller.sv
/*
 * game state machine
 * player and monster enables and resets, status bundle, stage controller
 */

`timescale 1ns/1ns

module game_controller (
	input  logic                     clk,
	input  logic                     resetN,
	input  game_pkg::board_cmd_t     cmd,
	input  logic                     win_stage,
	input  logic                     player_died,
	output game_pkg::block_enables_t enables,
	output game_pkg::block_resets_t  resets,
	output game_pkg::game_status_t   status
);

	import game_pkg::*;

	game_state_t    state_q;
	game_state_t    state_nxt;
	stage_num_t     stage;
	block_enables_t enemy_en;
	logic           last_stage;
	logic           stage_advance;
	logic           game_restart;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state_q <= ST_RESET;
		end else begin
			state_q <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			ST_RESET: begin
				if (cmd.start) state_nxt = ST_RUN;
			end
			ST_RUN: begin
				if (cmd.pause)                    state_nxt = ST_PAUSE;
				else if (player_died)             state_nxt = ST_GAME_OVER;
				else if (win_stage || cmd.skip)   state_nxt = last_stage ? ST_GAME_WON
				                                                         : ST_STAGE_WON;
			end
			ST_PAUSE: begin
				if (!cmd.pause) state_nxt = ST_RUN;
			end
			ST_STAGE_WON: state_nxt = ST_RUN; // single cycle
			ST_GAME_OVER,
			ST_GAME_WON: begin
				if (!cmd.start) state_nxt = ST_RESET; // wait for start switch down
			end
			default: state_nxt = ST_RESET;
		endcase
	end

	// outputs decode straight from state and stage
	always_comb begin
		enables = '0;
		resets  = '{player_n: 1'b1, monst_n: 1'b1};
		case (state_q)
			ST_RESET: resets = '0; // hold every block in reset
			ST_RUN: begin
				enables        = enemy_en;
				enables.player = 1'b1;
			end
			ST_STAGE_WON: resets.monst_n = 1'b0; // fresh enemies for next stage
			default: ;
		endcase
	end

	assign stage_advance = (state_q == ST_STAGE_WON);
	assign game_restart  = (state_q == ST_RESET);

	assign status.stage = stage;
	assign status.state = state_q;
	assign status.won   = (state_q == ST_GAME_WON);
	assign status.over  = (state_q == ST_GAME_OVER);

	stage_controller stage_controller_inst (
		.clk           (clk),
		.resetN        (resetN),
		.stage_advance (stage_advance),
		.game_restart  (game_restart),
		.stage         (stage),
		.enemy_en      (enemy_en),
		.last_stage    (last_stage)
	);

	a_outcome_exclusive: assert property (@(posedge clk) disable iff (!resetN)
		!(status.won && status.over))
		else $error("won and over raised together");

endmodule

//--- hw/game_top.sv
/*
 * game control top level
 * input conditioner feeding the game controller
 */

`timescale 1ns/1ns

module game_top (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     start_sw,
	input  logic                     pause_sw,
	input  logic                     skip_btn,
	input  logic                     win_stage,
	input  logic                     player_died,
	output game_pkg::block_enables_t enables,
	output game_pkg::block_resets_t  resets,
	output game_pkg::game_status_t   status
);

	import game_pkg::*;

	board_cmd_t cmd; // conditioned board commands

	input_conditioner input_conditioner_inst (
		.clk      (clk),
		.resetN   (resetN),
		.start_sw (start_sw),
		.pause_sw (pause_sw),
		.skip_btn (skip_btn),
		.cmd      (cmd)
	);

	game_controller game_controller_inst (
		.clk         (clk),
		.resetN      (resetN),
		.cmd         (cmd),
		.win_stage   (win_stage),   // already synchronous to clk
		.player_died (player_died),
		.enables     (enables),
		.resets      (resets),
		.status      (status)
	);

endmodule

//--- dv/game_tb.sv
/*
 * game control testbench
 * clock, reset, LFSR stimulus, reference model, output comparison, timeout
 */

`timescale 1ns/1ns
`include "game_cfg.svh"

module game_tb;

	import game_pkg::*;

	localparam int         CYCLE_LIMIT = 4000; // directed part + 3000 random + margin
	localparam stage_num_t BOSS        = stage_num_t'(`GAME_BOSS_STAGE);

	typedef struct packed {
		game_state_t state;
		stage_num_t  stage;
	} model_t;

	typedef struct packed {
		block_enables_t en;
		block_resets_t  rst;
		game_status_t   st;
	} expect_t;

	logic clk = 1'b0;
	logic resetN;
	logic start_sw;
	logic pause_sw;
	logic skip_btn;
	logic win_stage;
	logic player_died;
	block_enables_t enables;
	block_resets_t  resets;
	game_status_t   status;

	logic [2:0]  sync_sh [`GAME_SYNC_DEPTH]; // {start, pause, skip} per stage
	logic        m_skip_d;
	logic        m_skip_pulse;
	model_t      model;
	expect_t     exp_out;
	logic [15:0] lfsr = 16'd39;
	int          cycle_cnt = 0;

	game_top game_top_inst (
		.clk         (clk),
		.resetN      (resetN),
		.start_sw    (start_sw),
		.pause_sw    (pause_sw),
		.skip_btn    (skip_btn),
		.win_stage   (win_stage),
		.player_died (player_died),
		.enables     (enables),
		.resets      (resets),
		.status      (status)
	);

	always #10 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16,14,13,11
	endfunction

	task automatic take_bits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[6:0], lfsr[0]};
		end
	endtask

	// next state and stage from the synchronized commands and the event pulses
	function automatic model_t model_next(input model_t cur, input logic start,
			input logic pause, input logic skip, input logic win, input logic died);
		model_t n;
		n = cur;
		case (cur.state)
			ST_RESET: begin
				n.stage = '0;
				if (start) n.state = ST_RUN;
			end
			ST_RUN: begin
				if (pause) n.state = ST_PAUSE;
				else if (died) n.state = ST_GAME_OVER;
				else if ((win || skip) && cur.stage == BOSS) n.state = ST_GAME_WON;
				else if (win || skip) n.state = ST_STAGE_WON;
			end
			ST_PAUSE: if (!pause) n.state = ST_RUN;
			ST_STAGE_WON: begin
				n.state = ST_RUN;
				if (cur.stage != BOSS) n.stage = cur.stage + 3'd1;
			end
			ST_GAME_OVER, ST_GAME_WON: if (!start) n.state = ST_RESET;
			default: n.state = ST_RESET;
		endcase
		return n;
	endfunction

	function automatic expect_t expected_outputs(input model_t m);
		expect_t e;
		e           = '0;
		e.rst       = '{player_n: 1'b1, monst_n: 1'b1};
		e.st.stage  = m.stage;
		e.st.state  = m.state;
		e.st.won    = (m.state == ST_GAME_WON);
		e.st.over   = (m.state == ST_GAME_OVER);
		case (m.state)
			ST_RESET: e.rst = '0;
			ST_RUN: begin
				e.en.player = 1'b1;
				e.en.monst  = (m.stage < BOSS);
				e.en.astero = (m.stage < BOSS) && m.stage[0]; // odd stages only
				e.en.boss   = (m.stage == BOSS);
			end
			ST_STAGE_WON: e.rst.monst_n = 1'b0;
			default: ;
		endcase
		return e;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "test stopped");
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic wait_state(input game_state_t target);
		while (status.state != target) @(negedge clk);
	endtask

	// reference model sampled on the DUT's own edges
	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < `GAME_SYNC_DEPTH; i++) sync_sh[i] <= '0;
			m_skip_d     <= 1'b0;
			m_skip_pulse <= 1'b0;
			model        <= '{state: ST_RESET, stage: '0};
		end else begin
			sync_sh[0] <= {start_sw, pause_sw, skip_btn};
			for (int i = 1; i < `GAME_SYNC_DEPTH; i++) sync_sh[i] <= sync_sh[i-1];
			m_skip_d     <= sync_sh[`GAME_SYNC_DEPTH-1][0];
			m_skip_pulse <= sync_sh[`GAME_SYNC_DEPTH-1][0] & ~m_skip_d;
			model        <= model_next(model, sync_sh[`GAME_SYNC_DEPTH-1][2],
				sync_sh[`GAME_SYNC_DEPTH-1][1], m_skip_pulse, win_stage, player_died);
		end
	end

	always @(negedge clk) begin
		if (resetN) begin
			exp_out = expected_outputs(model);
			assert (enables == exp_out.en) else fail_now($sformatf(
				"MISMATCH t=%0t enables expected %b actual %b", $time, exp_out.en, enables));
			assert (resets == exp_out.rst) else fail_now($sformatf(
				"MISMATCH t=%0t resets expected %b actual %b", $time, exp_out.rst, resets));
			assert (status == exp_out.st) else fail_now($sformatf(
				"MISMATCH t=%0t status expected %h actual %h", $time, exp_out.st, status));
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) fail_now("test timed out before all phases finished");
	end

	initial begin
		int         monst_resets;
		int         won_cycles;
		logic [7:0] r;
		resetN      = 1'b0;
		start_sw    = 1'b0;
		pause_sw    = 1'b0;
		skip_btn    = 1'b0;
		win_stage   = 1'b0;
		player_died = 1'b0;
		repeat (4) @(posedge clk);
		#2 resetN = 1'b1;

		// idle after reset while the synchronizer holds start back
		repeat (4) begin
			@(negedge clk);
			assert (status.state == ST_RESET && enables == '0 && resets == '0
				&& status.stage == 3'd0) else fail_now("outputs not idle after reset");
		end
		next_cycle();
		start_sw = 1'b1;
		for (int i = 0; i <= `GAME_SYNC_DEPTH; i++) begin
			@(negedge clk);
			assert (status.state == ST_RESET) else fail_now("start seen before sync delay");
		end
		@(negedge clk);
		assert (status.state == ST_RUN) else fail_now("game did not start");

		// every stage cleared by win_stage
		for (int s = 0; s < `GAME_NUM_STAGES; s++) begin
			@(negedge clk);
			assert (status.state == ST_RUN && status.stage == stage_num_t'(s) && enables.player)
				else fail_now("stage did not begin in run state");
			assert (enables.monst == (s < `GAME_BOSS_STAGE)
				&& enables.astero == (s < `GAME_BOSS_STAGE && s % 2 == 1)
				&& enables.boss == (s == `GAME_BOSS_STAGE))
				else fail_now("wrong enemy mix for the stage kind");
			next_cycle();
			win_stage = 1'b1;
			next_cycle();
			win_stage    = 1'b0;
			monst_resets = 0;
			won_cycles   = 0;
			repeat (3) begin
				@(negedge clk);
				if (!resets.monst_n) monst_resets++;
				if (status.won) won_cycles++;
			end
			if (s < `GAME_BOSS_STAGE) begin
				assert (monst_resets == 1) else fail_now("monster reset not one cycle long");
			end else begin
				assert (won_cycles == 3 && monst_resets == 0) else fail_now("boss win not held");
			end
		end
		next_cycle();
		start_sw = 1'b0;
		wait_state(ST_RESET);
		next_cycle();
		start_sw = 1'b1;
		wait_state(ST_RUN);

		// pause on stage 1
		next_cycle();
		win_stage = 1'b1;
		next_cycle();
		win_stage = 1'b0;
		while (!(status.state == ST_RUN && status.stage == 3'd1)) @(negedge clk);
		next_cycle();
		pause_sw = 1'b1;
		wait_state(ST_PAUSE);
		repeat (5) begin
			@(negedge clk);
			assert (status.state == ST_PAUSE && enables == '0) else fail_now("pause not held");
		end
		next_cycle();
		pause_sw = 1'b0;
		wait_state(ST_RUN);
		assert (status.stage == 3'd1) else fail_now("stage changed across pause");

		// death followed by start switch down
		next_cycle();
		player_died = 1'b1;
		next_cycle();
		player_died = 1'b0;
		wait_state(ST_GAME_OVER);
		repeat (5) begin
			@(negedge clk);
			assert (status.over && !status.won) else fail_now("game over not held");
		end
		next_cycle();
		start_sw = 1'b0;
		wait_state(ST_RESET);
		@(negedge clk);
		assert (status.stage == 3'd0) else fail_now("stage not cleared after game over");

		// held skip button gives exactly one stage
		next_cycle();
		start_sw = 1'b1;
		wait_state(ST_RUN);
		next_cycle();
		skip_btn     = 1'b1;
		monst_resets = 0;
		repeat (16) begin
			@(negedge clk);
			if (status.state == ST_STAGE_WON) monst_resets++;
		end
		next_cycle();
		skip_btn = 1'b0;
		repeat (4) @(negedge clk);
		assert (monst_resets == 1 && status.stage == 3'd1 && status.state == ST_RUN)
			else fail_now("held skip did not advance exactly one stage");

		// random run checked by the comparing process
		repeat (3000) begin
			next_cycle();
			take_bits(3, r);
			start_sw = |r[2:0];   // mostly high
			take_bits(5, r);
			pause_sw = &r[4:0];   // rare
			take_bits(4, r);
			skip_btn = &r[3:0];
			take_bits(4, r);
			win_stage = &r[3:0];
			take_bits(6, r);
			player_died = &r[5:0]; // rarest
		end
		next_cycle();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- all.f
+incdir+hw
hw/game_pkg.sv
hw/input_conditioner.sv
hw/stage_controller.sv
hw/game_controller.sv
hw/game_top.sv
dv/game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the game control testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module game_tb -f all.f -o game_sim \
	&& ./obj_dir/game_sim \
	|| { echo "simulation failed"; exit 1; }
